/* source/iss_pkg.sv */
package iss_pkg;

  // MIPS word and register file geometry
  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // Return address sits past the branch and its delay slot
  localparam int LINK_OFFSET    = 8;

  // Functional class, selects the unit an instruction can issue to
  typedef enum logic [2:0] {
    ALU        = 3'd0,
    MULDIV     = 3'd1,
    LOAD_STORE = 3'd2,
    BRANCH     = 3'd3,
    JUMP       = 3'd4
  } inst_class_t;

  // Branch conditions; the signed tests compare operand A with zero
  typedef enum logic [2:0] {
    ALWAYS = 3'd0,
    EQ     = 3'd1,
    NE     = 3'd2,
    GT     = 3'd3,
    GE     = 3'd4,
    LT     = 3'd5,
    LE     = 3'd6
  } branch_cond_t;

  // Decoded instruction as held in the issue queue, 115 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0]     pc;
    inst_class_t               inst_class;
    logic [REG_ADDR_WIDTH-1:0] a_reg;
    logic [REG_ADDR_WIDTH-1:0] b_reg;
    logic                      a_reg_valid;
    logic                      b_reg_valid;
    logic [REG_ADDR_WIDTH-1:0] dest_reg;
    logic                      dest_reg_valid;
    // Jump target comes from operand A
    logic                      rformat;
    branch_cond_t              branch_cond;
    logic [DATA_WIDTH-1:0]     branch_target;
    logic [25:0]               imm;
  } dec_inst_t;

endpackage

/* source/operand_select.sv */
`timescale 1ns/1ps

module operand_select
  import iss_pkg::*;
#(
  parameter int ISSUE_WIDTH = 4
) (
  input  dec_inst_t                 insn          [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rf_a_data     [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rf_b_data     [ISSUE_WIDTH],
  input  logic                      rob_a_present [ISSUE_WIDTH],
  input  logic                      rob_a_valid   [ISSUE_WIDTH],
  input  logic                      rob_b_present [ISSUE_WIDTH],
  input  logic                      rob_b_valid   [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rob_a_data    [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rob_b_data    [ISSUE_WIDTH],
  output logic [REG_ADDR_WIDTH-1:0] src_a_reg     [ISSUE_WIDTH],
  output logic [REG_ADDR_WIDTH-1:0] src_b_reg     [ISSUE_WIDTH],
  output logic [DATA_WIDTH-1:0]     op_a          [ISSUE_WIDTH],
  output logic [DATA_WIDTH-1:0]     op_b          [ISSUE_WIDTH],
  output logic                      ops_ready     [ISSUE_WIDTH]
);

  logic a_ok [ISSUE_WIDTH];
  logic b_ok [ISSUE_WIDTH];

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
    // Same addresses feed the register file and the ROB lookup
    assign src_a_reg[i] = insn[i].a_reg;
    assign src_b_reg[i] = insn[i].b_reg;

    // A ROB copy is newer than the architectural value
    assign op_a[i] = rob_a_present[i] ? rob_a_data[i] : rf_a_data[i];
    assign op_b[i] = rob_b_present[i] ? rob_b_data[i] : rf_b_data[i];

    // Not needed, settled in the register file, or already produced
    assign a_ok[i] = !insn[i].a_reg_valid || !rob_a_present[i] || rob_a_valid[i];
    assign b_ok[i] = !insn[i].b_reg_valid || !rob_b_present[i] || rob_b_valid[i];

    assign ops_ready[i] = a_ok[i] && b_ok[i];
  end

endmodule

/* source/issue_dispatch.sv */
`timescale 1ns/1ps

module issue_dispatch
  import iss_pkg::*;
#(
  parameter int ISSUE_WIDTH    = 4,
  parameter int EX_UNITS       = 2,
  parameter int ROB_DEPTH_LOG2 = 4
) (
  input  logic                      clock,
  input  logic                      reset_n,
  input  logic                      insn_valid [ISSUE_WIDTH],
  input  dec_inst_t                 insn       [ISSUE_WIDTH],
  input  logic [ROB_DEPTH_LOG2-1:0] rob_slot   [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     op_a       [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     op_b       [ISSUE_WIDTH],
  input  logic                      ops_ready  [ISSUE_WIDTH],
  input  logic                      ls_ready,
  input  logic                      mul_ready,
  input  logic                      ex_ready   [EX_UNITS],
  output logic                      consumed   [ISSUE_WIDTH],
  output logic                      ls_valid,
  output dec_inst_t                 ls_inst,
  output logic [DATA_WIDTH-1:0]     ls_a,
  output logic [DATA_WIDTH-1:0]     ls_b,
  output logic [ROB_DEPTH_LOG2-1:0] ls_slot,
  output logic                      mul_valid,
  output dec_inst_t                 mul_inst,
  output logic [DATA_WIDTH-1:0]     mul_a,
  output logic [DATA_WIDTH-1:0]     mul_b,
  output logic [ROB_DEPTH_LOG2-1:0] mul_slot,
  output logic                      ex_valid   [EX_UNITS],
  output dec_inst_t                 ex_inst    [EX_UNITS],
  output logic [DATA_WIDTH-1:0]     ex_a       [EX_UNITS],
  output logic [DATA_WIDTH-1:0]     ex_b       [EX_UNITS],
  output logic [ROB_DEPTH_LOG2-1:0] ex_slot    [EX_UNITS],
  output logic                      br_issue,
  output dec_inst_t                 br_inst,
  output logic [DATA_WIDTH-1:0]     br_a,
  output logic [DATA_WIDTH-1:0]     br_b,
  output logic [ROB_DEPTH_LOG2-1:0] br_slot
);

  // Slot index picked for each unit this cycle
  int  ls_sel;
  int  mul_sel;
  int  ex_sel [EX_UNITS];
  logic ls_take;
  logic mul_take;
  logic ex_take [EX_UNITS];
  int  n_consumed;
  int  n_issued;

  always_comb begin
    logic stop;
    logic placed;
    int   br_sel;
    stop     = 1'b0;
    br_issue = 1'b0;
    br_sel   = 0;
    ls_take  = 1'b0;
    ls_sel   = 0;
    mul_take = 1'b0;
    mul_sel  = 0;
    for (int k = 0; k < EX_UNITS; k++) begin
      ex_take[k] = 1'b0;
      ex_sel[k]  = 0;
    end

    // Oldest first, the first slot that cannot go ends the walk
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      placed = 1'b0;
      if (!stop && insn_valid[i] && ops_ready[i]) begin
        case (insn[i].inst_class)
          BRANCH, JUMP: begin
            if (!br_issue) begin
              br_issue = 1'b1;
              br_sel   = i;
              placed   = 1'b1;
            end
          end
          LOAD_STORE: begin
            if (!ls_take && ls_ready) begin
              ls_take = 1'b1;
              ls_sel  = i;
              placed  = 1'b1;
            end
          end
          MULDIV: begin
            if (!mul_take && mul_ready) begin
              mul_take = 1'b1;
              mul_sel  = i;
              placed   = 1'b1;
            end
          end
          ALU: begin
            for (int k = 0; k < EX_UNITS; k++) begin
              if (!placed && !ex_take[k] && ex_ready[k]) begin
                ex_take[k] = 1'b1;
                ex_sel[k]  = i;
                placed     = 1'b1;
              end
            end
            // Multiplier doubles as a spare ALU
            if (!placed && !mul_take && mul_ready) begin
              mul_take = 1'b1;
              mul_sel  = i;
              placed   = 1'b1;
            end
          end
          default: placed = 1'b0;
        endcase
      end
      consumed[i] = placed;
      if (!placed) stop = 1'b1;
    end

    br_inst = insn[br_sel];
    br_a    = op_a[br_sel];
    br_b    = op_b[br_sel];
    br_slot = rob_slot[br_sel];
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ls_valid  <= 1'b0;
      mul_valid <= 1'b0;
      for (int k = 0; k < EX_UNITS; k++) ex_valid[k] <= 1'b0;
    end else begin
      ls_valid  <= ls_take;
      mul_valid <= mul_take;
      for (int k = 0; k < EX_UNITS; k++) ex_valid[k] <= ex_take[k];
    end
  end

  always_ff @(posedge clock) begin
    ls_inst  <= insn[ls_sel];
    ls_a     <= op_a[ls_sel];
    ls_b     <= op_b[ls_sel];
    ls_slot  <= rob_slot[ls_sel];
    mul_inst <= insn[mul_sel];
    mul_a    <= op_a[mul_sel];
    mul_b    <= op_b[mul_sel];
    mul_slot <= rob_slot[mul_sel];
    for (int k = 0; k < EX_UNITS; k++) begin
      ex_inst[k] <= insn[ex_sel[k]];
      ex_a[k]    <= op_a[ex_sel[k]];
      ex_b[k]    <= op_b[ex_sel[k]];
      ex_slot[k] <= rob_slot[ex_sel[k]];
    end
  end

  always_comb begin
    n_consumed = 0;
    for (int i = 0; i < ISSUE_WIDTH; i++) n_consumed += int'(consumed[i]);
    n_issued = int'(ls_valid) + int'(mul_valid);
    for (int k = 0; k < EX_UNITS; k++) n_issued += int'(ex_valid[k]);
  end

  // Queue removes a prefix, so a gap would lose an instruction
  for (genvar i = 1; i < ISSUE_WIDTH; i++) begin : g_prefix
    a_prefix : assert property (@(posedge clock) disable iff (!reset_n)
      consumed[i] |-> consumed[i-1]);
  end

  // Branches take a slot but no unit strobe
  a_issue_count : assert property (@(posedge clock) disable iff (!reset_n)
    n_issued <= $past(n_consumed));

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import iss_pkg::*;
#(
  parameter int ROB_DEPTH_LOG2 = 4
) (
  input  logic                      clock,
  input  logic                      reset_n,
  input  logic                      br_issue,
  input  dec_inst_t                 br_inst,
  input  logic [DATA_WIDTH-1:0]     br_a,
  input  logic [DATA_WIDTH-1:0]     br_b,
  input  logic [ROB_DEPTH_LOG2-1:0] br_slot,
  output logic [DATA_WIDTH-1:0]     new_pc,
  output logic                      new_pc_valid,
  output logic                      wr_valid,
  output logic [ROB_DEPTH_LOG2-1:0] wr_slot,
  output logic [DATA_WIDTH-1:0]     wr_link,
  output logic [REG_ADDR_WIDTH-1:0] wr_dest_reg,
  output logic                      wr_dest_valid,
  output logic                      wr_pc_valid
);

  logic ab_equal;
  logic a_gez;
  logic a_gtz;
  logic cond_ok;
  logic taken;

  assign ab_equal = (br_a == br_b);
  // Sign bit clear means A >= 0
  assign a_gez    = !br_a[DATA_WIDTH-1];
  assign a_gtz    = a_gez && (br_a != '0);

  always_comb begin
    case (br_inst.branch_cond)
      ALWAYS:  cond_ok = 1'b1;
      EQ:      cond_ok = ab_equal;
      NE:      cond_ok = !ab_equal;
      GT:      cond_ok = a_gtz;
      GE:      cond_ok = a_gez;
      LT:      cond_ok = !a_gez;
      LE:      cond_ok = !a_gtz;
      default: cond_ok = 1'b0;
    endcase
  end

  assign taken = (br_inst.inst_class == JUMP) || cond_ok;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wr_valid     <= 1'b0;
      new_pc_valid <= 1'b0;
    end else begin
      wr_valid     <= br_issue;
      new_pc_valid <= br_issue && taken;
    end
  end

  // Link write payload for the ROB entry of the branch
  always_ff @(posedge clock) begin
    new_pc        <= br_inst.rformat ? br_a : br_inst.branch_target;
    wr_slot       <= br_slot;
    wr_link       <= br_inst.pc + DATA_WIDTH'(LINK_OFFSET);
    wr_dest_reg   <= br_inst.dest_reg;
    wr_dest_valid <= br_inst.dest_reg_valid;
    wr_pc_valid   <= taken;
  end

  // Every redirect is backed by a ROB write for the same branch
  a_redirect_has_write : assert property (@(posedge clock) disable iff (!reset_n)
    new_pc_valid |-> wr_valid && wr_pc_valid);

endmodule

/* source/iss_top.sv */
`timescale 1ns/1ps

module iss_top
  import iss_pkg::*;
#(
  parameter int ISSUE_WIDTH    = 4,
  parameter int EX_UNITS       = 2,
  parameter int ROB_DEPTH_LOG2 = 4
) (
  input  logic                      clock,
  input  logic                      reset_n,
  // Issue queue
  input  logic                      insn_valid    [ISSUE_WIDTH],
  input  dec_inst_t                 insn          [ISSUE_WIDTH],
  input  logic [ROB_DEPTH_LOG2-1:0] rob_slot      [ISSUE_WIDTH],
  output logic                      consumed      [ISSUE_WIDTH],
  // Register file and ROB operand lookup
  output logic [REG_ADDR_WIDTH-1:0] src_a_reg     [ISSUE_WIDTH],
  output logic [REG_ADDR_WIDTH-1:0] src_b_reg     [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rf_a_data     [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rf_b_data     [ISSUE_WIDTH],
  input  logic                      rob_a_present [ISSUE_WIDTH],
  input  logic                      rob_a_valid   [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rob_a_data    [ISSUE_WIDTH],
  input  logic                      rob_b_present [ISSUE_WIDTH],
  input  logic                      rob_b_valid   [ISSUE_WIDTH],
  input  logic [DATA_WIDTH-1:0]     rob_b_data    [ISSUE_WIDTH],
  // Load/store unit
  input  logic                      ls_ready,
  output logic                      ls_valid,
  output dec_inst_t                 ls_inst,
  output logic [DATA_WIDTH-1:0]     ls_a,
  output logic [DATA_WIDTH-1:0]     ls_b,
  output logic [ROB_DEPTH_LOG2-1:0] ls_slot,
  // Multiply unit
  input  logic                      mul_ready,
  output logic                      mul_valid,
  output dec_inst_t                 mul_inst,
  output logic [DATA_WIDTH-1:0]     mul_a,
  output logic [DATA_WIDTH-1:0]     mul_b,
  output logic [ROB_DEPTH_LOG2-1:0] mul_slot,
  // EX units
  input  logic                      ex_ready      [EX_UNITS],
  output logic                      ex_valid      [EX_UNITS],
  output dec_inst_t                 ex_inst       [EX_UNITS],
  output logic [DATA_WIDTH-1:0]     ex_a          [EX_UNITS],
  output logic [DATA_WIDTH-1:0]     ex_b          [EX_UNITS],
  output logic [ROB_DEPTH_LOG2-1:0] ex_slot       [EX_UNITS],
  // Redirect and ROB link write
  output logic [DATA_WIDTH-1:0]     new_pc,
  output logic                      new_pc_valid,
  output logic                      wr_valid,
  output logic [ROB_DEPTH_LOG2-1:0] wr_slot,
  output logic [DATA_WIDTH-1:0]     wr_link,
  output logic [REG_ADDR_WIDTH-1:0] wr_dest_reg,
  output logic                      wr_dest_valid,
  output logic                      wr_pc_valid
);

  logic [DATA_WIDTH-1:0]     op_a      [ISSUE_WIDTH];
  logic [DATA_WIDTH-1:0]     op_b      [ISSUE_WIDTH];
  logic                      ops_ready [ISSUE_WIDTH];
  logic                      br_issue;
  dec_inst_t                 br_inst;
  logic [DATA_WIDTH-1:0]     br_a;
  logic [DATA_WIDTH-1:0]     br_b;
  logic [ROB_DEPTH_LOG2-1:0] br_slot;

  operand_select #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_operand_select (.*);

  issue_dispatch #(
    .ISSUE_WIDTH   (ISSUE_WIDTH),
    .EX_UNITS      (EX_UNITS),
    .ROB_DEPTH_LOG2(ROB_DEPTH_LOG2)
  ) u_issue_dispatch (.*);

  branch_unit #(.ROB_DEPTH_LOG2(ROB_DEPTH_LOG2)) u_branch_unit (.*);

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Release just after an edge so the next edge is the first active one
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset_n = 1'b1;
  end

endmodule

/* tests/tb_iss.sv */
`timescale 1ns/1ps

module tb_iss
  import iss_pkg::*;
;

  localparam int ISSUE_WIDTH  = 4;
  localparam int EX_UNITS     = 2;
  localparam int CLOCK_PERIOD = 8;
  // Unit indices run EX units first, then multiply, load/store and branch
  localparam int MUL_U = EX_UNITS;
  localparam int LS_U  = EX_UNITS + 1;
  localparam int BR_U  = EX_UNITS + 2;
  localparam int NU    = EX_UNITS + 2;
  localparam int TEST_CYCLES [6] = '{12, 150, 150, 200, 150, 150};

  typedef struct packed {
    logic        v;
    dec_inst_t   inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  slot;
  } unit_t;

  typedef struct packed {
    logic        wr_valid;
    logic        npc_valid;
    logic [31:0] new_pc;
    logic [3:0]  slot;
    logic [31:0] link;
    logic [4:0]  dest;
    logic        dest_v;
    logic        pc_valid;
  } br_t;

  logic        clock;
  logic        reset_n;
  logic        insn_valid    [ISSUE_WIDTH];
  dec_inst_t   insn          [ISSUE_WIDTH];
  logic [3:0]  rob_slot      [ISSUE_WIDTH];
  logic        consumed      [ISSUE_WIDTH];
  logic [4:0]  src_a_reg     [ISSUE_WIDTH];
  logic [4:0]  src_b_reg     [ISSUE_WIDTH];
  logic [31:0] rf_a_data     [ISSUE_WIDTH];
  logic [31:0] rf_b_data     [ISSUE_WIDTH];
  logic [31:0] rob_a_data    [ISSUE_WIDTH];
  logic [31:0] rob_b_data    [ISSUE_WIDTH];
  logic        rob_a_present [ISSUE_WIDTH];
  logic        rob_a_valid   [ISSUE_WIDTH];
  logic        rob_b_present [ISSUE_WIDTH];
  logic        rob_b_valid   [ISSUE_WIDTH];
  logic        ls_ready, ls_valid, mul_ready, mul_valid;
  dec_inst_t   ls_inst, mul_inst;
  logic [31:0] ls_a, ls_b, mul_a, mul_b;
  logic [3:0]  ls_slot, mul_slot;
  logic        ex_ready [EX_UNITS];
  logic        ex_valid [EX_UNITS];
  dec_inst_t   ex_inst  [EX_UNITS];
  logic [31:0] ex_a     [EX_UNITS];
  logic [31:0] ex_b     [EX_UNITS];
  logic [3:0]  ex_slot  [EX_UNITS];
  logic [31:0] new_pc, wr_link;
  logic        new_pc_valid, wr_valid, wr_dest_valid, wr_pc_valid;
  logic [3:0]  wr_slot;
  logic [4:0]  wr_dest_reg;

  // Reference state for the coming edge (nxt_) and for the edge just taken (exp_)
  logic        exp_consumed [ISSUE_WIDTH];
  unit_t       nxt_u   [NU];
  unit_t       exp_u   [NU];
  logic        nxt_rdy [NU];
  logic        exp_rdy [NU];
  br_t         nxt_br;
  br_t         exp_br;
  logic [31:0] lfsr = 32'd6;
  int          errors = 0;
  int          checks = 0;

  tb_clock #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(10)) u_clock (.clock(clock), .reset_n(reset_n));

  iss_top #(.ISSUE_WIDTH(ISSUE_WIDTH), .EX_UNITS(EX_UNITS), .ROB_DEPTH_LOG2(4)) dut (.*);

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "reset";
      1: return "operand sourcing";
      2: return "class routing";
      3: return "back-pressure";
      4: return "branch conditions";
      default: return "link write";
    endcase
  endfunction

  function automatic string sig_name(input int u, input string f);
    if (u < EX_UNITS) return $sformatf("ex_%s[%0d]", f, u);
    return $sformatf("%s_%s", (u == MUL_U) ? "mul" : "ls", f);
  endfunction

  task automatic check(input string name, input logic [191:0] got, input logic [191:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Expected issue for the current inputs by the dispatch and branch rules
  function automatic void predict();
    logic        free [NU + 1];
    logic        go;
    logic        rdy;
    logic        taken;
    logic [31:0] a;
    logic [31:0] b;
    int          u;
    for (int k = 0; k < EX_UNITS; k++) free[k] = ex_ready[k];
    free[MUL_U] = mul_ready;
    free[LS_U]  = ls_ready;
    free[BR_U]  = 1'b1;
    for (int k = 0; k < NU; k++) begin
      nxt_rdy[k]  = free[k];
      nxt_u[k].v  = 1'b0;
    end
    nxt_br.wr_valid  = 1'b0;
    nxt_br.npc_valid = 1'b0;
    go = 1'b1;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      a   = rob_a_present[i] ? rob_a_data[i] : rf_a_data[i];
      b   = rob_b_present[i] ? rob_b_data[i] : rf_b_data[i];
      rdy = (!insn[i].a_reg_valid || !rob_a_present[i] || rob_a_valid[i]) &&
            (!insn[i].b_reg_valid || !rob_b_present[i] || rob_b_valid[i]);
      u = -1;
      if (go && insn_valid[i] && rdy) begin
        case (insn[i].inst_class)
          LOAD_STORE:   u = free[LS_U] ? LS_U : -1;
          MULDIV:       u = free[MUL_U] ? MUL_U : -1;
          BRANCH, JUMP: u = free[BR_U] ? BR_U : -1;
          ALU: begin
            for (int k = EX_UNITS - 1; k >= 0; k--) if (free[k]) u = k;
            if (u < 0 && free[MUL_U]) u = MUL_U;
          end
          default: u = -1;
        endcase
      end
      go = go && (u >= 0);
      exp_consumed[i] = go;
      if (go) begin
        free[u] = 1'b0;
        if (u == BR_U) begin
          case (insn[i].branch_cond)
            ALWAYS:  taken = 1'b1;
            EQ:      taken = (a == b);
            NE:      taken = (a != b);
            GT:      taken = ($signed(a) > 0);
            GE:      taken = ($signed(a) >= 0);
            LT:      taken = ($signed(a) < 0);
            LE:      taken = ($signed(a) <= 0);
            default: taken = 1'b0;
          endcase
          taken  = taken || (insn[i].inst_class == JUMP);
          nxt_br = '{1'b1, taken, insn[i].rformat ? a : insn[i].branch_target, rob_slot[i],
                     insn[i].pc + 32'd8, insn[i].dest_reg, insn[i].dest_reg_valid, taken};
        end else begin
          nxt_u[u] = '{1'b1, insn[i], a, b, rob_slot[i]};
        end
      end
    end
  endfunction

  task automatic compare_outputs();
    unit_t act;
    for (int u = 0; u < NU; u++) begin
      if (u < EX_UNITS) act = '{ex_valid[u], ex_inst[u], ex_a[u], ex_b[u], ex_slot[u]};
      else if (u == MUL_U) act = '{mul_valid, mul_inst, mul_a, mul_b, mul_slot};
      else act = '{ls_valid, ls_inst, ls_a, ls_b, ls_slot};
      check(sig_name(u, "valid"), 192'(act.v), 192'(exp_u[u].v));
      assert (!(act.v === 1'b1 && !exp_rdy[u])) else begin
        errors++;
        $display("At %0t ns unit %s got an instruction while not ready", $time, sig_name(u, "*"));
      end
      if (exp_u[u].v) begin
        check(sig_name(u, "inst/a/b/slot"), 192'({act.inst, act.a, act.b, act.slot}),
              192'({exp_u[u].inst, exp_u[u].a, exp_u[u].b, exp_u[u].slot}));
      end
    end
    check("wr_valid", 192'(wr_valid), 192'(exp_br.wr_valid));
    check("new_pc_valid", 192'(new_pc_valid), 192'(exp_br.npc_valid));
    if (exp_br.wr_valid) begin
      check("wr_slot/link/dest_reg/dest_valid/pc_valid",
            192'({wr_slot, wr_link, wr_dest_reg, wr_dest_valid, wr_pc_valid}),
            192'({exp_br.slot, exp_br.link, exp_br.dest, exp_br.dest_v, exp_br.pc_valid}));
    end
    if (exp_br.npc_valid) check("new_pc", 192'(new_pc), 192'(exp_br.new_pc));
  endtask

  // Mode picks the stimulus profile of each test
  task automatic drive(input int mode);
    logic [127:0] raw;
    logic [1:0]   pick;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      raw     = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
      insn[i] = raw[114:0];
      case (mode)
        4:       insn[i].inst_class = (take_bits(2) == 0) ? JUMP : BRANCH;
        5:       insn[i].inst_class = inst_class_t'(3'(take_bits(3) % 5));
        default: insn[i].inst_class = inst_class_t'(3'(take_bits(2) % 3));
      endcase
      insn[i].branch_cond = branch_cond_t'(3'(take_bits(3) % 7));
      insn_valid[i]    = (take_bits(3) != 0);
      rob_slot[i]      = 4'(take_bits(4));
      rf_a_data[i]     = take_bits(32);
      rf_b_data[i]     = take_bits(32);
      rob_a_data[i]    = take_bits(32);
      rob_b_data[i]    = take_bits(32);
      rob_a_present[i] = (take_bits(1) != 0);
      rob_b_present[i] = (take_bits(1) != 0);
      rob_a_valid[i]   = (mode inside {0, 1, 3}) ? (take_bits(1) != 0) : 1'b1;
      rob_b_valid[i]   = (mode inside {0, 1, 3}) ? (take_bits(1) != 0) : 1'b1;
      if (mode == 4) begin
        // Equal and zero operands hit the condition boundaries
        pick = 2'(take_bits(2));
        rob_a_present[i] = 1'b0;
        rob_b_present[i] = 1'b0;
        if (pick == 2'd0) rf_b_data[i] = rf_a_data[i];
        if (pick == 2'd1) rf_a_data[i] = '0;
      end
    end
    ls_ready  = (mode inside {0, 3, 5}) ? (take_bits(1) != 0) : 1'b1;
    mul_ready = (mode inside {0, 3, 5}) ? (take_bits(1) != 0) : 1'b1;
    for (int k = 0; k < EX_UNITS; k++) begin
      ex_ready[k] = (mode inside {0, 2, 3, 5}) ? (take_bits(1) != 0) : 1'b1;
    end
  endtask

  // Inputs and registered outputs are settled at the falling edge
  initial begin
    for (int k = 0; k < NU; k++) begin
      exp_u[k]   = '0;
      exp_rdy[k] = 1'b1;
    end
    exp_br = '0;
    @(posedge clock);
    forever begin
      @(negedge clock);
      compare_outputs();
      predict();
      for (int i = 0; i < ISSUE_WIDTH; i++) begin
        check($sformatf("consumed[%0d]", i), 192'(consumed[i]), 192'(exp_consumed[i]));
        check($sformatf("src_a_reg[%0d]", i), 192'(src_a_reg[i]), 192'(insn[i].a_reg));
        check($sformatf("src_b_reg[%0d]", i), 192'(src_b_reg[i]), 192'(insn[i].b_reg));
      end
      if (!reset_n) begin
        for (int k = 0; k < NU; k++) nxt_u[k].v = 1'b0;
        nxt_br.wr_valid  = 1'b0;
        nxt_br.npc_valid = 1'b0;
      end
      exp_u   = nxt_u;
      exp_rdy = nxt_rdy;
      exp_br  = nxt_br;
    end
  end

  initial begin
    int start;
    drive(0);
    for (int t = 0; t < 6; t++) begin
      start = errors;
      repeat (TEST_CYCLES[t]) begin
        @(posedge clock);
        #1;
        drive(t);
      end
      $display("Test %0d (%s) finished with %0d errors", t, test_name(t), errors - start);
    end
    repeat (2) @(posedge clock);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    int total;
    total = 20;
    foreach (TEST_CYCLES[t]) total += TEST_CYCLES[t];
    #(total * CLOCK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
source/iss_pkg.sv
source/operand_select.sv
source/issue_dispatch.sv
source/branch_unit.sv
source/iss_top.sv
tests/tb_clock.sv
tests/tb_iss.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_iss -f sources.f

sim:
	verilator --binary --timing --assert --top-module tb_iss -Mdir obj_dir -f sources.f
	./obj_dir/Vtb_iss > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
